/* src/exec_pkg.sv */
package exec_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass  // lui, result is operand b
  } alu_op_t;

  // same order as funct3 of the M extension
  typedef enum logic [2:0] {
    md_mul,
    md_mulh,
    md_mulhsu,
    md_mulhu,
    md_div,
    md_divu,
    md_rem,
    md_remu
  } muldiv_op_t;

  typedef enum logic [3:0] {
    exc_none = 4'd0,
    exc_illegal_instruction = 4'd2,
    exc_breakpoint = 4'd3,
    exc_env_call_mach = 4'd11
  } exc_cause_t;

  typedef enum logic [6:0] {
    opc_op = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui = 7'b0110111,
    opc_system = 7'b1110011
  } opcode_t;

  typedef struct packed {
    alu_op_t alu_op;
    muldiv_op_t muldiv_op;
    logic [31:0] imm;  // sign extended, or upper for lui
    logic rden1;
    logic rden2;
    logic wren;
    logic use_imm;
    logic muldiv;
    logic ecall;
    logic ebreak;
    logic valid;
  } decoded_t;

  typedef struct packed {
    logic valid;
    logic [31:0] pc;
    logic [31:0] instr;
  } issue_t;

  typedef struct packed {
    logic valid;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [4:0] rd;
    logic wren;
    logic [31:0] wdata;
    logic exception;
    exc_cause_t ecause;
  } retire_t;

endpackage

/* src/post_decoder.sv */
`timescale 1ns/1ns

module post_decoder (
  input logic [31:0] instr,
  output exec_pkg::decoded_t dec
);

  exec_pkg::opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  exec_pkg::alu_op_t base_op;

  assign opcode = exec_pkg::opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // funct3 map shared by op and op_imm
  always_comb begin
    case (funct3)
      3'b000: base_op = exec_pkg::alu_add;
      3'b001: base_op = exec_pkg::alu_sll;
      3'b010: base_op = exec_pkg::alu_slt;
      3'b011: base_op = exec_pkg::alu_sltu;
      3'b100: base_op = exec_pkg::alu_xor;
      3'b101: base_op = exec_pkg::alu_srl;
      3'b110: base_op = exec_pkg::alu_or;
      default: base_op = exec_pkg::alu_and;
    endcase
  end

  always_comb begin
    dec = '0;
    dec.alu_op = exec_pkg::alu_add;
    dec.muldiv_op = exec_pkg::md_mul;
    case (opcode)
      exec_pkg::opc_op: begin
        dec.rden1 = 1'b1;
        dec.rden2 = 1'b1;
        dec.wren = 1'b1;
        dec.valid = 1'b1;
        if (funct7 == 7'b0000001) begin
          dec.muldiv = 1'b1;
          dec.muldiv_op = exec_pkg::muldiv_op_t'(funct3);
        end else if (funct7 == 7'b0000000) begin
          dec.alu_op = base_op;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          dec.alu_op = exec_pkg::alu_sub;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b101) begin
          dec.alu_op = exec_pkg::alu_sra;
        end else begin
          dec.valid = 1'b0;
        end
      end
      exec_pkg::opc_op_imm: begin
        dec.rden1 = 1'b1;
        dec.wren = 1'b1;
        dec.use_imm = 1'b1;
        dec.valid = 1'b1;
        dec.imm = {{20{instr[31]}}, instr[31:20]};
        dec.alu_op = base_op;
        if (funct3 == 3'b001 && funct7 != 7'b0000000) begin
          dec.valid = 1'b0;  // bad slli
        end else if (funct3 == 3'b101) begin
          if (funct7 == 7'b0100000) begin
            dec.alu_op = exec_pkg::alu_sra;
          end else if (funct7 != 7'b0000000) begin
            dec.valid = 1'b0;
          end
        end
      end
      exec_pkg::opc_lui: begin
        dec.wren = 1'b1;
        dec.use_imm = 1'b1;
        dec.valid = 1'b1;
        dec.imm = {instr[31:12], 12'b0};
        dec.alu_op = exec_pkg::alu_pass;
      end
      exec_pkg::opc_system: begin
        dec.ecall = (instr == 32'h0000_0073);
        dec.ebreak = (instr == 32'h0010_0073);
        dec.valid = dec.ecall | dec.ebreak;  // no csr support
      end
      default: dec.valid = 1'b0;
    endcase
  end

endmodule

/* src/int_alu.sv */
`timescale 1ns/1ns

module int_alu (
  input logic [31:0] a,
  input logic [31:0] b,
  input exec_pkg::alu_op_t op,
  output logic [31:0] res
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      exec_pkg::alu_add: res = a + b;
      exec_pkg::alu_sub: res = a - b;
      exec_pkg::alu_sll: res = a << shamt;
      exec_pkg::alu_slt: begin
        res = {31'b0, $signed(a) < $signed(b)};
      end
      exec_pkg::alu_sltu: begin
        res = {31'b0, a < b};
      end
      exec_pkg::alu_xor: res = a ^ b;
      exec_pkg::alu_srl: res = a >> shamt;
      exec_pkg::alu_sra: begin
        res = $unsigned($signed(a) >>> shamt);
      end
      exec_pkg::alu_or: res = a | b;
      exec_pkg::alu_and: res = a & b;
      exec_pkg::alu_pass: res = b;  // lui
      default: res = 32'b0;
    endcase
  end

endmodule

/* src/muldiv_unit.sv */
`timescale 1ns/1ns

module muldiv_unit (
  input logic clock,
  input logic reset,
  input logic start,
  input exec_pkg::muldiv_op_t op,
  input logic [31:0] a,
  input logic [31:0] b,
  output logic done,
  output logic [31:0] result
);

  typedef enum logic [1:0] {idle, run, finish} state_t;

  state_t state;
  logic [63:0] acc;  // {partial product or remainder, multiplier or quotient}
  logic [31:0] operand;  // multiplicand or divisor magnitude
  logic [4:0] count;
  exec_pkg::muldiv_op_t op_q;
  logic neg_res;
  logic neg_rem;

  logic is_div, a_signed, b_signed, a_neg, b_neg;
  logic [31:0] a_mag, b_mag;
  logic div_zero, overflow;
  logic [32:0] prod_sum;
  logic [33:0] div_trial;
  logic [63:0] mul_next, div_next;
  logic [63:0] prod;
  logic [31:0] quo, rem;

  always_comb begin
    is_div = op[2];
    a_signed = op inside {exec_pkg::md_mulh, exec_pkg::md_mulhsu, exec_pkg::md_div,
                          exec_pkg::md_rem};
    b_signed = op inside {exec_pkg::md_mulh, exec_pkg::md_div, exec_pkg::md_rem};
    a_neg = a_signed & a[31];
    b_neg = b_signed & b[31];
    a_mag = a_neg ? -a : a;
    b_mag = b_neg ? -b : b;
    div_zero = is_div && b == 32'b0;
    overflow = (op == exec_pkg::md_div || op == exec_pkg::md_rem) &&
               a == 32'h8000_0000 && b == 32'hffff_ffff;

    prod_sum = {1'b0, acc[63:32]} + {1'b0, operand};  // one add and shift step
    mul_next = acc[0] ? {prod_sum, acc[31:1]} : {1'b0, acc[63:1]};
    div_trial = {1'b0, acc[63:31]} - {2'b0, operand};  // restoring step
    div_next = div_trial[33] ? {acc[62:0], 1'b0} : {div_trial[31:0], acc[30:0], 1'b1};

    prod = neg_res ? -acc : acc;
    quo = neg_res ? -acc[31:0] : acc[31:0];
    rem = neg_rem ? -acc[63:32] : acc[63:32];
    case (op_q)
      exec_pkg::md_mul: result = prod[31:0];
      exec_pkg::md_mulh, exec_pkg::md_mulhsu, exec_pkg::md_mulhu: result = prod[63:32];
      exec_pkg::md_div, exec_pkg::md_divu: result = quo;
      default: result = rem;
    endcase
  end

  assign done = (state == finish);

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= idle;
      count <= 5'd0;
    end else begin
      case (state)
        idle: if (start) begin
          op_q <= op;
          count <= 5'd0;
          neg_res <= 1'b0;
          neg_rem <= 1'b0;
          if (div_zero) begin
            acc <= {a, 32'hffff_ffff};
            state <= finish;
          end else if (overflow) begin
            acc <= {32'b0, a};
            state <= finish;
          end else begin
            operand <= is_div ? b_mag : a_mag;
            acc <= {32'b0, is_div ? a_mag : b_mag};
            neg_res <= a_neg ^ b_neg;
            neg_rem <= a_neg;  // remainder takes sign of dividend
            state <= run;
          end
        end
        run: begin
          acc <= op_q[2] ? div_next : mul_next;
          count <= count + 5'd1;
          if (count == 5'd31) begin
            state <= finish;
          end
        end
        default: state <= idle;
      endcase
    end
  end

endmodule

/* src/register_file.sv */
`timescale 1ns/1ns

module register_file (
  input logic clock,
  input logic [4:0] raddr1,
  input logic [4:0] raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input logic wren,
  input logic [4:0] waddr,
  input logic [31:0] wdata
);

  logic [31:0] regs [1:31];  // x0 has no storage

  always_comb begin
    if (raddr1 == 5'd0) begin
      rdata1 = 32'b0;
    end else begin
      rdata1 = regs[raddr1];
    end
  end

  always_comb begin
    if (raddr2 == 5'd0) begin
      rdata2 = 32'b0;
    end else begin
      rdata2 = regs[raddr2];
    end
  end

  always_ff @(posedge clock) begin
    if (wren && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage (
  input logic clock,
  input logic reset,
  input logic instr_valid,
  input logic [31:0] instr_pc,
  input logic [31:0] instr_word,
  output logic busy,
  input exec_pkg::decoded_t dec,
  output logic [31:0] dec_instr,
  output logic [4:0] raddr1,
  output logic [4:0] raddr2,
  input logic [31:0] rdata1,
  input logic [31:0] rdata2,
  output logic [31:0] alu_a,
  output logic [31:0] alu_b,
  output exec_pkg::alu_op_t alu_op,
  input logic [31:0] alu_res,
  output logic md_start,
  output exec_pkg::muldiv_op_t md_op,
  output logic [31:0] md_a,
  output logic [31:0] md_b,
  input logic md_done,
  input logic [31:0] md_result,
  output logic rf_wren,
  output logic [4:0] rf_waddr,
  output logic [31:0] rf_wdata,
  output exec_pkg::retire_t retire
);

  exec_pkg::issue_t issue_q;
  exec_pkg::retire_t retire_d;
  exec_pkg::retire_t retire_q;
  logic md_started;  // start already sent for the op in issue
  logic stall;
  logic [31:0] op1, op2;

  assign dec_instr = issue_q.instr;
  assign raddr1 = issue_q.instr[19:15];
  assign raddr2 = issue_q.instr[24:20];

  // unused operands read as zero
  assign op1 = dec.rden1 ? rdata1 : 32'b0;
  assign op2 = dec.rden2 ? rdata2 : 32'b0;

  assign alu_a = op1;
  assign alu_b = dec.use_imm ? dec.imm : op2;
  assign alu_op = dec.alu_op;

  assign md_a = op1;
  assign md_b = op2;
  assign md_op = dec.muldiv_op;
  assign md_start = issue_q.valid & dec.muldiv & ~md_started;

  assign stall = issue_q.valid & dec.muldiv & ~md_done;
  assign busy = stall;

  always_comb begin
    retire_d.valid = issue_q.valid & ~stall;
    retire_d.pc = issue_q.pc;
    retire_d.instr = issue_q.instr;
    retire_d.rd = issue_q.instr[11:7];
    retire_d.wren = dec.wren && retire_d.rd != 5'd0;
    retire_d.wdata = dec.muldiv ? md_result : alu_res;
    retire_d.exception = 1'b1;
    if (!dec.valid) begin
      retire_d.ecause = exec_pkg::exc_illegal_instruction;
    end else if (dec.ebreak) begin
      retire_d.ecause = exec_pkg::exc_breakpoint;
    end else if (dec.ecall) begin
      retire_d.ecause = exec_pkg::exc_env_call_mach;
    end else begin
      retire_d.exception = 1'b0;
      retire_d.ecause = exec_pkg::exc_none;
    end
    if (retire_d.exception) begin
      retire_d.wren = 1'b0;  // no write on exception
      retire_d.wdata = 32'b0;
    end
  end

  assign rf_wren = retire_d.valid & retire_d.wren;
  assign rf_waddr = retire_d.rd;
  assign rf_wdata = retire_d.wdata;

  assign retire = retire_q;

  always_ff @(posedge clock) begin
    if (!reset) begin
      issue_q.valid <= 1'b0;
      retire_q.valid <= 1'b0;
      md_started <= 1'b0;
    end else begin
      if (instr_valid && !busy) begin
        issue_q <= '{valid: 1'b1, pc: instr_pc, instr: instr_word};
      end else if (!stall) begin
        issue_q.valid <= 1'b0;
      end
      if (md_done) begin
        md_started <= 1'b0;
      end else if (md_start) begin
        md_started <= 1'b1;
      end
      retire_q <= retire_d;
    end
  end

endmodule

/* src/execute_top.sv */
`timescale 1ns/1ns

module execute_top (
  input logic clock,
  input logic reset,
  input logic instr_valid,
  input logic [31:0] instr_pc,
  input logic [31:0] instr_word,
  output logic busy,
  output exec_pkg::retire_t retire
);

  exec_pkg::decoded_t dec;
  logic [31:0] dec_instr;
  logic [4:0] raddr1, raddr2;
  logic [31:0] rdata1, rdata2;
  logic [31:0] alu_a, alu_b, alu_res;
  exec_pkg::alu_op_t alu_op;
  logic md_start, md_done;
  exec_pkg::muldiv_op_t md_op;
  logic [31:0] md_a, md_b, md_result;
  logic rf_wren;
  logic [4:0] rf_waddr;
  logic [31:0] rf_wdata;

  execute_stage stage_i (.*);

  post_decoder decoder_i (.instr(dec_instr), .dec(dec));

  int_alu alu_i (.a(alu_a), .b(alu_b), .op(alu_op), .res(alu_res));

  muldiv_unit muldiv_i (.clock(clock), .reset(reset), .start(md_start), .op(md_op),
    .a(md_a), .b(md_b), .done(md_done), .result(md_result));

  register_file regfile_i (.clock(clock), .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1),
    .rdata2(rdata2), .wren(rf_wren), .waddr(rf_waddr), .wdata(rf_wdata));

endmodule

/* verification/clock_gen.sv */
`timescale 1ns/1ns

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    reset = 1'b0;  // low through the first two rising edges
    repeat (2) @(posedge clock);
    reset <= 1'b1;
  end

  always #20 clock = ~clock;  // 40 ns period

endmodule

/* verification/execute_tb.sv */
`timescale 1ns/1ns

module execute_tb;

  localparam int n_instr = 2000;  // first 31 load known register values
  localparam int timeout_cycles = n_instr * 40 + 100;

  logic clock;
  logic reset;
  logic instr_valid;
  logic [31:0] instr_pc;
  logic [31:0] instr_word;
  logic busy;
  exec_pkg::retire_t retire;

  exec_pkg::retire_t expect_q[$];
  int accept_q[$];  // acceptance edge, -1 for multiply/divide
  exec_pkg::retire_t expected;
  int accept_edge;
  logic [31:0] model_regs [0:31] = '{default: 32'b0};
  logic [31:0] pc = 32'h0000_1000;
  int edge_count = 0;
  int busy_check_edge = -1;
  logic will_accept = 1'b0;  // inputs get taken at the coming edge
  logic busy_prev = 1'b0;

  clock_gen clock_gen_i (.clock(clock), .reset(reset));

  execute_top dut_i (.clock(clock), .reset(reset), .instr_valid(instr_valid),
    .instr_pc(instr_pc), .instr_word(instr_word), .busy(busy), .retire(retire));

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected_value);
    if (actual !== expected_value) begin
      fail_run($sformatf("ERROR %s: got %h, expected %h", name, actual, expected_value));
    end
  endtask

  function automatic logic [31:0] muldiv_ref(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0] prod;
    int sa;
    int sb;
    sa = a;
    sb = b;
    case (f3)
      3'd1: prod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
      3'd2: prod = {{32{a[31]}}, a} * {32'b0, b};
      default: prod = {32'b0, a} * {32'b0, b};
    endcase
    if (f3 == 3'd0) return prod[31:0];
    if (!f3[2]) return prod[63:32];
    if (b == 32'b0) return f3[1] ? a : 32'hffff_ffff;  // divide by zero
    if (f3[0]) return f3[1] ? a % b : a / b;
    if (a == 32'h8000_0000 && b == 32'hffff_ffff) return f3[1] ? 32'b0 : a;
    return f3[1] ? 32'(sa % sb) : 32'(sa / sb);
  endfunction

  // architectural result of one instruction, updates the model registers
  function automatic exec_pkg::retire_t model_step(input logic [31:0] ipc,
                                                   input logic [31:0] w);
    exec_pkg::retire_t r;
    exec_pkg::exc_cause_t cause;
    logic [31:0] a, b, res;
    logic [2:0] f3;
    logic [6:0] f7;
    logic legal;
    int sa, sb;
    f3 = w[14:12];
    f7 = w[31:25];
    a = model_regs[w[19:15]];
    b = w[5] ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};  // op_imm uses imm
    sa = a;
    sb = b;
    legal = 1'b1;
    cause = exec_pkg::exc_none;
    res = 32'b0;
    case (w[6:0])
      exec_pkg::opc_lui: res = {w[31:12], 12'b0};
      exec_pkg::opc_op, exec_pkg::opc_op_imm: begin
        if (w[5] && f7 == 7'b0000001) begin
          res = muldiv_ref(f3, a, b);
        end else begin
          if (w[5]) legal = f7 == 7'b0 || (f7 == 7'b0100000 && (f3 == 3'd0 || f3 == 3'd5));
          else if (f3 == 3'd1) legal = f7 == 7'b0;
          else if (f3 == 3'd5) legal = f7 == 7'b0 || f7 == 7'b0100000;
          case (f3)
            3'd0: res = (w[5] && w[30]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, sa < sb};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: res = 32'({{32{a[31] & w[30]}}, a} >> b[4:0]);  // srl or sra
            3'd6: res = a | b;
            default: res = a & b;
          endcase
        end
      end
      exec_pkg::opc_system: begin
        if (w == 32'h0000_0073) cause = exec_pkg::exc_env_call_mach;
        else if (w == 32'h0010_0073) cause = exec_pkg::exc_breakpoint;
        else legal = 1'b0;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) cause = exec_pkg::exc_illegal_instruction;
    r = '0;
    r.valid = 1'b1;
    r.pc = ipc;
    r.instr = w;
    r.rd = w[11:7];
    r.exception = cause != exec_pkg::exc_none;
    r.ecause = cause;
    if (!r.exception) begin
      r.wdata = res;
      r.wren = r.rd != 5'd0;
      if (r.wren) model_regs[r.rd] = res;
    end
    return r;
  endfunction

  function automatic logic [31:0] random_instr(input int index);
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3;
    logic [31:0] w;
    int pick;
    rd = 5'($urandom_range(0, 29));  // x30 and x31 keep the overflow operands
    rs1 = 5'($urandom_range(0, 31));
    rs2 = 5'($urandom_range(0, 31));
    f3 = 3'($urandom_range(0, 7));
    pick = $urandom_range(0, 99);
    w = $urandom();
    if (index < 29) return {20'($urandom()), 5'(index + 1), exec_pkg::opc_lui};
    if (index == 29) return {20'h80000, 5'd30, exec_pkg::opc_lui};
    if (index == 30) return {12'hfff, 5'd0, 3'd0, 5'd31, exec_pkg::opc_op_imm};
    if (pick < 10) return {w[31:12], rd, exec_pkg::opc_lui};
    if (pick < 50) begin
      if (f3 == 3'd1) w[31:25] = 7'b0;
      if (f3 == 3'd5) w[31:25] = {1'b0, w[30], 5'b0};
      return {w[31:20], rs1, f3, rd, exec_pkg::opc_op_imm};
    end
    if (pick < 75) begin
      w[31:25] = {1'b0, (f3 == 3'd0 || f3 == 3'd5) && w[0], 5'b0};  // sub and sra
      return {w[31:25], rs2, rs1, f3, rd, exec_pkg::opc_op};
    end
    if (pick < 80) return {7'b1, 5'd0, rs1, 1'b1, f3[1:0], rd, exec_pkg::opc_op};
    if (pick < 83) return {7'b1, 5'd31, 5'd30, 1'b1, f3[1], 1'b0, rd, exec_pkg::opc_op};
    if (pick < 90) return {7'b1, rs2, rs1, f3, rd, exec_pkg::opc_op};
    if (pick < 93) return 32'h0000_0073;
    if (pick < 96) return 32'h0010_0073;
    if (pick < 99) return {w[31:7], w[6], 6'b100011};  // store or branch opcode
    return {7'b0100000, rs2, rs1, 3'd1, rd, exec_pkg::opc_op_imm};  // bad slli
  endfunction

  task automatic send_instr(input logic [31:0] word, input int gap);
    instr_valid <= 1'b0;
    repeat (gap) @(posedge clock);
    while (busy_prev) @(posedge clock);
    instr_valid <= 1'b1;
    instr_pc <= pc;
    instr_word <= word;
    @(posedge clock);
    while (!will_accept) @(posedge clock);  // held while busy
    pc = pc + 32'd4;
  endtask

  always @(posedge clock) begin
    edge_count <= edge_count + 1;
    if (edge_count >= timeout_cycles) fail_run("the run timed out before all retires came");
  end

  always @(negedge clock) begin
    if (reset) begin
      if (retire.valid) begin
        if (expect_q.size() == 0) begin
          fail_run("a retire arrived with no instruction outstanding");
        end else begin
          expected = expect_q.pop_front();
          accept_edge = accept_q.pop_front();
          check_value("retire.pc", retire.pc, expected.pc);
          check_value("retire.instr", retire.instr, expected.instr);
          check_value("retire.rd", 32'(retire.rd), 32'(expected.rd));
          check_value("retire.wren", 32'(retire.wren), 32'(expected.wren));
          check_value("retire.exception", 32'(retire.exception), 32'(expected.exception));
          check_value("retire.ecause", 32'(retire.ecause), 32'(expected.ecause));
          if (!expected.exception) check_value("retire.wdata", retire.wdata, expected.wdata);
          if (accept_edge < 0) check_value("busy before retire", 32'(busy_prev), 32'd0);
          else check_value("retire edge", edge_count, accept_edge + 1);
        end
      end
      if (edge_count == busy_check_edge) check_value("busy", 32'(busy), 32'd1);
      will_accept = instr_valid && !busy;
      if (will_accept) begin
        expect_q.push_back(model_step(instr_pc, instr_word));
        if (instr_word[6:0] == exec_pkg::opc_op && instr_word[31:25] == 7'b0000001) begin
          accept_q.push_back(-1);
          busy_check_edge = edge_count + 1;
        end else begin
          accept_q.push_back(edge_count + 1);
        end
      end
      busy_prev = busy;
    end
  end

  initial begin
    instr_valid = 1'b0;
    instr_pc = 32'b0;
    instr_word = 32'b0;
    void'($urandom(32'h75b2));
    @(posedge reset);
    @(negedge clock);
    check_value("retire.valid", 32'(retire.valid), 32'd0);
    check_value("busy", 32'(busy), 32'd0);
    @(posedge clock);
    for (int i = 0; i < n_instr; i++) begin
      send_instr(random_instr(i), $urandom_range(0, 2));
    end
    instr_valid <= 1'b0;
    while (expect_q.size() != 0) @(posedge clock);
    repeat (40) @(posedge clock);  // room for a stray retire
    if (expect_q.size() == 0 && accept_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      fail_run("instructions were still outstanding at the end of the run");
    end
  end

endmodule

/* files.f */
src/exec_pkg.sv
src/post_decoder.sv
src/int_alu.sv
src/muldiv_unit.sv
src/register_file.sv
src/execute_stage.sv
src/execute_top.sv
verification/clock_gen.sv
verification/execute_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --top-module execute_tb -f files.f -o execute_tb
	./obj_dir/execute_tb | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir
